// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := sdSpiCardTb
FILELIST  := sdSpiCard.f
OBJDIR    := obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: compile
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// ==== bench/sdSpiCardTb.sv ====
// SD SPI card testbench: directed host-model tests of init, read, write and error responses
`default_nettype none
`include "sd_params.svh"

module sdSpiCardTb;
   import sdProtoPkg::*;
   import sdCardPkg::*;

   localparam int TIMEOUT_CYCLES = 40000;  // about twice the length of all tests
   localparam int BLOCK = `SD_BLOCK_BYTES;

   logic     sclk;
   logic     rstn;
   logic     ncs;
   logic     mosi;
   logic     miso;
   int       cycles = 0;
   int       seed;
   dataByteT wrData [BLOCK];
   dataByteT rdData [BLOCK];

   sdSpiCard dut_i (
      .sclk(sclk),
      .rstn(rstn),
      .ncs(ncs),
      .mosi(mosi),
      .miso(miso)
   );

   always #5 sclk = ~sclk;

   always @(posedge sclk) begin
      cycles <= cycles + 1;
      if (cycles >= TIMEOUT_CYCLES) begin
         $display("TB FAILED");
         $fatal(1, "simulation timed out");
      end
   end

   // R1 status followed by an all-ones tail
   function automatic respT r1Word(input logic [7:0] status);
      return {status, 32'hFFFF_FFFF};
   endfunction

   // power-up memory content, low byte of address plus 3
   function automatic dataByteT patternByte(input int block, input int idx);
      return dataByteT'(block * BLOCK + idx + 3);
   endfunction

   task automatic failRun(input string what);
      $display("%s", what);
      $display("TB FAILED");
      $fatal(1, "stopped at first error");
   endtask

   task automatic checkResp(input string test, input respT exp, input respT act);
      if (act !== exp)
         failRun($sformatf("error %s: expected %h, actual %h", test, exp, act));
   endtask

   task automatic checkByte(input string test, input dataByteT exp, input dataByteT act);
      if (act !== exp)
         failRun($sformatf("error %s: expected %h, actual %h", test, exp, act));
   endtask

   task automatic resetCard();
      @(posedge sclk);
      rstn <= 1'b0;
      ncs <= 1'b1;
      mosi <= 1'b1;
      repeat (2) @(posedge sclk);
      rstn <= 1'b1;
   endtask

   task automatic sendByte(input dataByteT b);
      for (int i = 7; i >= 0; i--) begin
         @(posedge sclk);
         mosi <= b[i];
      end
   endtask

   // start, transmission bit, index, argument, dummy CRC and end bit
   task automatic sendCmd(input logic [5:0] index, input logic [31:0] arg);
      logic [47:0] frame;
      frame = {2'b01, index, arg, 8'hFF};
      @(posedge sclk);
      ncs <= 1'b0;
      mosi <= 1'b1;
      sendByte(8'hFF);   // eight idle clocks before the frame
      for (int i = 47; i >= 0; i--) begin
         @(posedge sclk);
         mosi <= frame[i];
      end
   endtask

   // samples on falling edges, miso is stable there
   task automatic waitLevel(input logic level, input int limit, input string what);
      int n;
      n = 0;
      @(negedge sclk);
      while (miso !== level) begin
         n++;
         if (n >= limit)
            failRun(what);
         @(negedge sclk);
      end
   endtask

   task automatic getResp(output respT r);
      waitLevel(1'b0, 64, "card gave no response to a command");
      r = '0;              // first bit is the low MSB just seen
      repeat (39) begin
         @(negedge sclk);
         r = {r[38:0], miso};
      end
   endtask

   task automatic getByte(output dataByteT b);
      repeat (8) begin
         @(negedge sclk);
         b = {b[6:0], miso};
      end
   endtask

   task automatic huntToken(input int limit, output bit found);
      dataByteT window;
      window = 8'hFF;
      found = 1'b0;
      for (int i = 0; i < limit && !found; i++) begin
         @(negedge sclk);
         window = {window[6:0], miso};
         found = window == 8'hFE;
      end
   endtask

   task automatic initCard(input string test);
      respT r;
      sendCmd(6'd0, 32'h0);
      getResp(r);
      checkResp({test, " CMD0"}, r1Word(8'h01), r);
      sendCmd(6'd8, 32'h1AA);
      getResp(r);
      checkResp({test, " CMD8"}, {8'h01, 20'h0, 4'h1, 8'hAA}, r);
      sendCmd(6'd55, 32'h0);
      getResp(r);
      checkResp({test, " CMD55"}, r1Word(8'h01), r);
      sendCmd(6'd41, 32'h4000_0000);
      getResp(r);
      checkResp({test, " ACMD41"}, r1Word(8'h00), r);
      sendCmd(6'd58, 32'h0);
      getResp(r);
      checkResp({test, " CMD58"}, {8'h00, `SD_OCR}, r);
   endtask

   task automatic readBlock(input string test, input int block);
      respT     r;
      bit       found;
      dataByteT crc;
      sendCmd(6'd17, 32'(block));
      getResp(r);
      checkResp({test, " R1"}, r1Word(8'h00), r);
      huntToken(64, found);
      if (!found)
         failRun($sformatf("%s: no start token after the read command", test));
      for (int i = 0; i < BLOCK; i++)
         getByte(rdData[i]);
      getByte(crc);
      checkByte({test, " crc high"}, 8'hAA, crc);
      getByte(crc);
      checkByte({test, " crc low"}, 8'hAA, crc);
   endtask

   task automatic vhsMismatch();
      respT r;
      resetCard();
      sendCmd(6'd0, 32'h0);
      getResp(r);
      checkResp("vhs mismatch CMD0", r1Word(8'h01), r);
      sendCmd(6'd8, 32'h2AA);
      getResp(r);
      checkResp("vhs mismatch CMD8", {8'h01, 20'h0, 4'h0, 8'hAA}, r);
   endtask

   task automatic readBeforeInit();
      respT r;
      bit   found;
      sendCmd(6'd17, 32'h1);
      getResp(r);
      checkResp("read before init", r1Word(8'h01), r);
      huntToken(64, found);
      if (found)
         failRun("start token sent before initialization finished");
      sendCmd(6'd5, 32'h0);   // no such command in this card
      getResp(r);
      checkResp("unknown command", r1Word(8'h05), r);
   endtask

   task automatic blockRead();
      resetCard();
      initCard("read init");
      readBlock("block read", 1);
      for (int i = 0; i < BLOCK; i++)
         checkByte($sformatf("block read byte %0d", i), patternByte(1, i), rdData[i]);
   endtask

   task automatic writeReadBack();
      respT     r;
      dataByteT dr;
      for (int i = 0; i < BLOCK; i++)
         wrData[i] = dataByteT'($random(seed));
      sendCmd(6'd24, 32'h2);
      getResp(r);
      checkResp("write R1", r1Word(8'h00), r);
      sendByte(8'hFF);
      sendByte(8'hFE);
      for (int i = 0; i < BLOCK; i++)
         sendByte(wrData[i]);
      sendByte(8'hFF);    // CRC, not checked by the card
      sendByte(8'hFF);
      waitLevel(1'b0, 16, "no data response after the write block");
      dr = '0;
      repeat (7) begin
         @(negedge sclk);
         dr = {dr[6:0], miso};
      end
      checkByte("write data response", 8'h05, dr);
      waitLevel(1'b0, 16, "card did not signal busy after the write");
      waitLevel(1'b1, 2 * `SD_BUSY_CYCLES, "card stayed busy after the write");
      readBlock("read back", 2);
      for (int i = 0; i < BLOCK; i++)
         checkByte($sformatf("read back byte %0d", i), wrData[i], rdData[i]);
   endtask

   task automatic blockOutOfRange();
      respT r;
      bit   found;
      sendCmd(6'd17, 32'(`SD_MEM_BLOCKS));
      getResp(r);
      checkResp("out of range read", r1Word(8'h20), r);
      huntToken(64, found);
      if (found)
         failRun("start token sent for a block beyond the memory");
   endtask

   initial begin
      sclk = 1'b0;
      rstn = 1'b0;
      ncs = 1'b1;
      mosi = 1'b1;
      seed = 88;
      resetCard();
      initCard("init");
      vhsMismatch();
      readBeforeInit();
      blockRead();
      writeReadBack();
      blockOutOfRange();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== logic/sdBitSerializer.sv ====
// MSB-first shifter onto a serial line for any packed payload type, line idles high
`default_nettype none

module sdBitSerializer #(
   parameter type payloadT = logic [7:0]
) (
   input  logic    sclk,
   input  logic    rstn,
   input  logic    load,
   input  payloadT payload,
   output logic    serial,
   output logic    done
);
   localparam int W = $bits(payloadT);
   localparam int CNT_W = $clog2(W + 1);

   logic [W-1:0]     shReg;
   logic [CNT_W-1:0] bitsLeft;
   logic             active;

   assign serial = active ? shReg[W-1] : 1'b1;

   // marks the final bit, a load in this cycle follows with no gap
   assign done = active && bitsLeft == CNT_W'(1);

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         active <= 1'b0;
         bitsLeft <= '0;
      end else if (load) begin
         active <= 1'b1;
         bitsLeft <= CNT_W'(W);
      end else if (active) begin
         active <= !done;
         bitsLeft <= bitsLeft - 1'b1;
      end
   end

   always_ff @(posedge sclk) begin
      if (load)
         shReg <= payload;
      else
         shReg <= {shReg[W-2:0], 1'b1};
   end

   // caller only reloads at the last bit or when idle
   loadWhileShifting: assert property (@(posedge sclk) disable iff (!rstn)
      load |-> !active || done)
      else $error("serializer reloaded mid-payload");

endmodule

`default_nettype wire

// ==== logic/sdCardPkg.sv ====
// SD card internal types: initialization stage, transfer kind and the job passed to the data path
`default_nettype none

package sdCardPkg;

   // init sequence CMD0, CMD8, CMD55, ACMD41
   typedef enum logic [2:0] {
      INIT_RESET,
      INIT_CMD0,
      INIT_CMD8,
      INIT_CMD55,
      INIT_READY
   } initStageT;

   typedef enum logic [1:0] {
      XFER_NONE,
      XFER_READ,
      XFER_WRITE
   } xferKindT;

   // one decoded command for the transfer unit
   typedef struct packed {
      sdProtoPkg::respT resp;
      xferKindT         kind;
      logic [7:0]       block;  // block number, SDHC addressing
   } cardJobT;

endpackage

`default_nettype wire

// ==== logic/sdCmdDecoder.sv ====
// SD command decoder: tracks initialization, builds the response word and the transfer job
`default_nettype none
`include "sd_params.svh"

module sdCmdDecoder (
   input  logic                 sclk,
   input  logic                 rstn,
   input  sdProtoPkg::cmdFrameT cmd,
   input  logic                 cmdValid,
   output sdCardPkg::cardJobT   job,
   output logic                 jobValid
);
   import sdProtoPkg::*;
   import sdCardPkg::*;

   initStageT  stage;
   initStageT  nextStage;
   logic       appCmd;      // last command was CMD55
   logic       isAcmd41;
   logic       isRw;
   logic       legal;
   logic       blockErr;
   logic [7:0] status;
   logic [3:0] vhsEcho;
   respT       resp;
   xferKindT   kind;

   always_comb begin
      isAcmd41 = appCmd && cmd.index == 6'd41;
      isRw = cmd.index == 6'd17 || cmd.index == 6'd24;
      case (cmd.index)
         6'd0, 6'd8, 6'd17, 6'd24, 6'd55, 6'd58: legal = 1'b1;
         default: legal = isAcmd41;
      endcase
      blockErr = isRw && cmd.arg >= 32'(`SD_MEM_BLOCKS);

      // CMD0 restarts the sequence from any stage
      nextStage = stage;
      if (cmd.index == 6'd0)
         nextStage = INIT_CMD0;
      else if (stage == INIT_CMD0 && cmd.index == 6'd8)
         nextStage = INIT_CMD8;
      else if (stage == INIT_CMD8 && cmd.index == 6'd55)
         nextStage = INIT_CMD55;
      else if (stage == INIT_CMD55 && cmd.index != 6'd55)
         nextStage = isAcmd41 ? INIT_READY : INIT_CMD8;  // anything else drops the app prefix

      status = 8'h00;
      status[R1_IDLE] = nextStage != INIT_READY;   // so ACMD41 itself answers 00
      status[R1_ILLEGAL] = !legal;
      status[R1_ADDR_ERR] = blockErr;

      vhsEcho = (cmd.arg[11:8] == `SD_CARD_VHS) ? cmd.arg[11:8] : 4'h0;
      case (cmd.index)
         6'd8: resp = {status, 20'h00000, vhsEcho, cmd.arg[7:0]};  // R7
         6'd58: resp = {status, `SD_OCR};                         // R3
         default: resp = {status, 32'hFFFF_FFFF};                 // R1, tail idles high
      endcase

      kind = XFER_NONE;
      if (stage == INIT_READY && !blockErr) begin
         if (cmd.index == 6'd17)
            kind = XFER_READ;
         else if (cmd.index == 6'd24)
            kind = XFER_WRITE;
      end
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         stage <= INIT_RESET;
         appCmd <= 1'b0;
         jobValid <= 1'b0;
      end else begin
         jobValid <= cmdValid;
         if (cmdValid) begin
            stage <= nextStage;
            appCmd <= cmd.index == 6'd55;
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (cmdValid) begin
         job.resp <= resp;
         job.kind <= kind;
         job.block <= cmd.arg[7:0];
      end
   end

endmodule

`default_nettype wire

// ==== logic/sdCmdReceiver.sv ====
// SD command receiver that detects the start bit on mosi and captures a 48-bit command frame
`default_nettype none

module sdCmdReceiver (
   input  logic                 sclk,
   input  logic                 rstn,
   input  logic                 ncs,
   input  logic                 mosi,
   input  logic                 busy,
   output sdProtoPkg::cmdFrameT cmd,
   output logic                 cmdValid
);
   import sdProtoPkg::*;

   logic        active;
   logic [5:0]  bitCnt;  // bits sampled so far including the start bit
   logic [47:0] shReg;
   logic        startBit;

   assign startBit = !ncs && !active && !busy && !mosi;

   // frame stays put in shReg while cmdValid is high
   assign cmd.index = shReg[45:40];
   assign cmd.arg = shReg[39:8];

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         active <= 1'b0;
         bitCnt <= '0;
         cmdValid <= 1'b0;
      end else begin
         cmdValid <= 1'b0;
         if (ncs) begin           // deselect drops a partial frame
            active <= 1'b0;
            bitCnt <= '0;
         end else if (startBit) begin
            active <= 1'b1;
            bitCnt <= 6'd1;
         end else if (active && bitCnt == 6'd47) begin
            active <= 1'b0;
            bitCnt <= '0;
            cmdValid <= 1'b1;
         end else if (active) begin
            bitCnt <= bitCnt + 1'b1;
         end
      end
   end

   always_ff @(posedge sclk) begin
      if (startBit || (active && !ncs))
         shReg <= {shReg[46:0], mosi};
   end

   // host keeps the card selected while a command is handed on
   validOnlySelected: assert property (@(posedge sclk) disable iff (!rstn)
      cmdValid |-> !ncs)
      else $error("command completed while card deselected");

endmodule

`default_nettype wire

// ==== logic/sdProtoPkg.sv ====
// SD SPI protocol wire formats: command frame, response word, data bytes and tokens
`default_nettype none

package sdProtoPkg;

   // index and argument of a 48-bit frame, start, CRC and end bits dropped
   typedef struct packed {
      logic [5:0]  index;
      logic [31:0] arg;
   } cmdFrameT;

   // status byte first, unused tail padded with ones
   typedef logic [39:0] respT;

   typedef logic [7:0] dataByteT;

   // R1 status bit positions
   localparam int unsigned R1_IDLE = 0;
   localparam int unsigned R1_ILLEGAL = 2;
   localparam int unsigned R1_ADDR_ERR = 5;

   localparam dataByteT TOKEN_START = 8'hFE;    // single block read and write
   localparam dataByteT DATA_ACCEPTED = 8'h05;  // data response, accepted

   // fixed read CRC, no CRC16 generation
   localparam logic [15:0] READ_CRC = 16'hAAAA;

endpackage

`default_nettype wire

// ==== logic/sdSpiCard.sv ====
// SD card SPI-mode slave: command receiver, decoder and transfer unit chained from mosi to miso
`default_nettype none

module sdSpiCard (
   input  logic sclk,
   input  logic rstn,
   input  logic ncs,
   input  logic mosi,
   output logic miso
);
   import sdProtoPkg::*;
   import sdCardPkg::*;

   cmdFrameT cmd;
   logic     cmdValid;
   cardJobT  job;
   logic     jobValid;
   logic     busy;      // mutes the receiver during a transfer

   sdCmdReceiver receiver_i (
      .sclk(sclk),
      .rstn(rstn),
      .ncs(ncs),
      .mosi(mosi),
      .busy(busy),
      .cmd(cmd),
      .cmdValid(cmdValid)
   );

   sdCmdDecoder decoder_i (
      .sclk(sclk),
      .rstn(rstn),
      .cmd(cmd),
      .cmdValid(cmdValid),
      .job(job),
      .jobValid(jobValid)
   );

   sdTransfer transfer_i (
      .sclk(sclk),
      .rstn(rstn),
      .mosi(mosi),
      .job(job),
      .jobValid(jobValid),
      .miso(miso),
      .busy(busy)
   );

endmodule

`default_nettype wire

// ==== logic/sdTransfer.sv ====
// SD transfer unit holding the block memory and sequencing the response, read, write and busy phases on miso
`default_nettype none
`include "sd_params.svh"

module sdTransfer (
   input  logic               sclk,
   input  logic               rstn,
   input  logic               mosi,
   input  sdCardPkg::cardJobT job,
   input  logic               jobValid,
   output logic               miso,
   output logic               busy
);
   import sdProtoPkg::*;
   import sdCardPkg::*;

   localparam int BLOCK = `SD_BLOCK_BYTES;
   localparam int DEPTH = `SD_BLOCK_BYTES * `SD_MEM_BLOCKS;
   localparam int ADDR_W = $clog2(DEPTH);
   localparam int IDX_W = $clog2(BLOCK + 3);  // data bytes plus two CRC bytes
   localparam int CNT_W = 16;

   typedef enum logic [3:0] {
      PH_IDLE,
      PH_NCR,
      PH_RESP,
      PH_NAC,
      PH_RDDATA,
      PH_WRHUNT,
      PH_WRDATA,
      PH_DRESP,
      PH_BUSY
   } phaseT;

   phaseT             phase;
   cardJobT           jobQ;
   logic [CNT_W-1:0]  cnt;
   logic [IDX_W-1:0]  byteIdx;
   logic [2:0]        bitIdx;
   logic [ADDR_W-1:0] addr;
   dataByteT          mem [DEPTH];
   dataByteT          memRd;
   logic [6:0]        shIn;      // last seven mosi samples
   dataByteT          wrByte;
   dataByteT          bytePayload;
   logic              respLoad;
   logic              respDone;
   logic              respLine;
   logic              byteLoad;
   logic              byteDone;
   logic              byteLine;

   initial begin
      for (int i = 0; i < DEPTH; i++)
         mem[i] = dataByteT'(i + 3);  // power-up pattern is the low address byte plus 3
   end

   assign addr = ADDR_W'(jobQ.block) * ADDR_W'(BLOCK) + ADDR_W'(byteIdx);
   assign wrByte = {shIn, mosi};
   assign busy = jobValid || phase != PH_IDLE;
   assign miso = respLine && byteLine && phase != PH_BUSY;

   always_comb begin
      respLoad = phase == PH_NCR && cnt == '0;
      case (phase)
         PH_NAC: byteLoad = cnt == '0;                                  // start token
         PH_RDDATA: byteLoad = byteDone && byteIdx < IDX_W'(BLOCK + 2);
         PH_WRDATA: byteLoad = bitIdx == 3'd7 && byteIdx == IDX_W'(BLOCK + 1);
         default: byteLoad = 1'b0;
      endcase
      if (phase == PH_NAC)
         bytePayload = TOKEN_START;
      else if (phase != PH_RDDATA)
         bytePayload = DATA_ACCEPTED;
      else if (byteIdx < IDX_W'(BLOCK))
         bytePayload = memRd;
      else if (byteIdx == IDX_W'(BLOCK))
         bytePayload = READ_CRC[15:8];
      else
         bytePayload = READ_CRC[7:0];
   end

   always_ff @(posedge sclk) begin
      if (!rstn) begin
         phase <= PH_IDLE;
         cnt <= '0;
         byteIdx <= '0;
         bitIdx <= '0;
      end else begin
         case (phase)
            PH_IDLE: if (jobValid) begin
               phase <= PH_NCR;
               cnt <= CNT_W'(`SD_NCR_BYTES * 8 - 1);
            end
            PH_NCR:
               if (respLoad)
                  phase <= PH_RESP;
               else
                  cnt <= cnt - 1'b1;
            PH_RESP: if (respDone) begin
               if (jobQ.kind == XFER_READ) begin
                  phase <= PH_NAC;
                  cnt <= CNT_W'(`SD_NAC_BYTES * 8 - 1);
               end else if (jobQ.kind == XFER_WRITE) begin
                  phase <= PH_WRHUNT;
               end else begin
                  phase <= PH_IDLE;
               end
            end
            PH_NAC: if (byteLoad) begin
               phase <= PH_RDDATA;
               byteIdx <= '0;
            end else begin
               cnt <= cnt - 1'b1;
            end
            PH_RDDATA: if (byteDone) begin
               if (byteLoad)
                  byteIdx <= byteIdx + 1'b1;
               else
                  phase <= PH_IDLE;
            end
            PH_WRHUNT: if (wrByte == TOKEN_START) begin  // token ends on its only 0
               phase <= PH_WRDATA;
               byteIdx <= '0;
               bitIdx <= '0;
            end
            PH_WRDATA: begin
               bitIdx <= bitIdx + 1'b1;
               if (bitIdx == 3'd7)
                  byteIdx <= byteIdx + 1'b1;
               if (byteLoad)
                  phase <= PH_DRESP;     // second CRC byte in
            end
            PH_DRESP: if (byteDone) begin
               phase <= PH_BUSY;
               cnt <= CNT_W'(`SD_BUSY_CYCLES - 1);
            end
            PH_BUSY:
               if (cnt == '0)
                  phase <= PH_IDLE;
               else
                  cnt <= cnt - 1'b1;
            default: phase <= PH_IDLE;
         endcase
      end
   end

   always_ff @(posedge sclk) begin
      if (jobValid)
         jobQ <= job;
      shIn <= wrByte[6:0];
      memRd <= mem[addr];   // index stays fixed for a whole byte before it is loaded
      if (phase == PH_WRDATA && bitIdx == 3'd7 && byteIdx < IDX_W'(BLOCK))
         mem[addr] <= wrByte;
   end

   sdBitSerializer #(.payloadT(respT)) respSer_i (
      .sclk(sclk),
      .rstn(rstn),
      .load(respLoad),
      .payload(jobQ.resp),
      .serial(respLine),
      .done(respDone)
   );

   sdBitSerializer #(.payloadT(dataByteT)) byteSer_i (
      .sclk(sclk),
      .rstn(rstn),
      .load(byteLoad),
      .payload(bytePayload),
      .serial(byteLine),
      .done(byteDone)
   );

   // host must wait for the previous transfer since the receiver gating relies on it
   jobWhileBusy: assert property (@(posedge sclk) disable iff (!rstn)
      jobValid |-> phase == PH_IDLE)
      else $error("new command while card busy");

endmodule

`default_nettype wire

// ==== logic/sd_params.svh ====
// SD card SPI model constants: block geometry, response gaps, busy length, OCR and voltage code
`ifndef SD_PARAMS_SVH
`define SD_PARAMS_SVH

// block geometry, SDHC style fixed block length
`define SD_BLOCK_BYTES 512
`define SD_MEM_BLOCKS 4

// idle bytes before the response and before the read start token
`define SD_NCR_BYTES 1
`define SD_NAC_BYTES 1

// miso held low this long after the data response of a write
`define SD_BUSY_CYCLES 100

// power-up done and CCS set, 2.7 to 3.6 V window
`define SD_OCR 32'hC0FF8000

// accepted VHS code in CMD8
`define SD_CARD_VHS 4'h1

`endif

// ==== sdSpiCard.f ====
+incdir+logic
logic/sdProtoPkg.sv
logic/sdCardPkg.sv
logic/sdCmdReceiver.sv
logic/sdCmdDecoder.sv
logic/sdBitSerializer.sv
logic/sdTransfer.sv
logic/sdSpiCard.sv
bench/sdSpiCardTb.sv
